/* hw/zxuno_pkg.sv */
package zxuno_pkg;

  // ----------------------------------------------------------
  // bus and register types
  // ----------------------------------------------------------

  // full 16-bit z80 i/o address
  typedef logic [15:0] io_addr_t;
  // data bus byte, both directions
  typedef logic [7:0] byte_t;
  // extended register number, as held in the address latch
  typedef logic [7:0] reg_addr_t;
  // 9 bits cover every line of a frame
  typedef logic [8:0] raster_line_t;

  // ----------------------------------------------------------
  // ports and register numbers
  // ----------------------------------------------------------

  // both ports fully decoded
  localparam io_addr_t PORT_ADDR = 16'hFC3B;
  localparam io_addr_t PORT_DATA = 16'hFD3B;

  localparam reg_addr_t REG_COREID     = 8'hFF;
  localparam reg_addr_t REG_SCRATCH    = 8'hFE;
  localparam reg_addr_t REG_DEVOPTIONS = 8'h0E;
  localparam reg_addr_t REG_RASTERLINE = 8'h0C;
  localparam reg_addr_t REG_RASTERCTRL = 8'h0D;

  // identification string
  localparam int COREID_LEN = 8;
  // index must be able to sit on COREID_LEN itself
  localparam int COREID_IDX_W = $clog2(COREID_LEN + 1);
  // first character lives in the top byte
  localparam logic [8*COREID_LEN-1:0] COREID_STR = "ZXREG001";

  // nothing drives the bus, pull-ups win
  localparam byte_t FLOATING_BUS = 8'hFF;

  // reset values of the option registers
  localparam byte_t SCRATCH_RST    = 8'h00;
  localparam byte_t DEVOPTIONS_RST = 8'h00;
  localparam byte_t RASTERLINE_RST = 8'h00;
  localparam byte_t RASTERCTRL_RST = 8'h00;

endpackage

/* hw/zxuno_port_decoder.sv */
`timescale 1ns/1ns

module zxuno_port_decoder (
  input  logic                 sysclk,
  input  logic                 rst,
  input  zxuno_pkg::io_addr_t  a,
  input  zxuno_pkg::byte_t     d_in,
  input  logic                 iorq_n,
  input  logic                 rd_n,
  input  logic                 wr_n,
  output zxuno_pkg::reg_addr_t zxuno_addr,
  output logic                 regrd,
  output logic                 regwr,
  output logic                 regaddr_changed,
  output logic                 oe_addr,
  output zxuno_pkg::byte_t     addr_dout
);

  logic hit_addr;
  logic hit_data;
  logic io_rd;
  logic io_wr;
  logic io_wr_q;
  logic wr_first;

  // ----------------------------------------------------------
  // z80 i/o cycle decode
  // ----------------------------------------------------------

  // full address compare, no partial decode
  assign hit_addr = (a == zxuno_pkg::PORT_ADDR);
  assign hit_data = (a == zxuno_pkg::PORT_DATA);

  // exactly one strobe together with iorq_n
  assign io_rd = ~iorq_n & ~rd_n & wr_n;
  assign io_wr = ~iorq_n & ~wr_n & rd_n;

  // first cycle of a write that may last several cycles
  assign wr_first = io_wr & ~io_wr_q;

  // ----------------------------------------------------------
  // address latch
  // ----------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      io_wr_q         <= 1'b0;
      zxuno_addr      <= '0;
      regaddr_changed <= 1'b0;
    end else begin
      io_wr_q <= io_wr;
      // pulse lands one cycle after the latch edge
      regaddr_changed <= hit_addr & wr_first;
      if (hit_addr && wr_first) begin
        zxuno_addr <= d_in;
      end
    end
  end

  // data port strobes for the register devices
  // read is a level for the whole access
  assign regrd = hit_data & io_rd;
  // write is a single pulse
  assign regwr = hit_data & wr_first;

  // readback of the selected number on FC3B
  assign oe_addr   = hit_addr & io_rd;
  assign addr_dout = zxuno_addr;

  // a z80 i/o cycle never pulls both strobes low
  assert property (@(posedge sysclk) disable iff (rst) !(!iorq_n && !rd_n && !wr_n))
    else $error("rd_n and wr_n low together in one i/o cycle");

endmodule

/* hw/coreid_string.sv */
`timescale 1ns/1ns

module coreid_string (
  input  logic                 sysclk,
  input  logic                 rst,
  input  zxuno_pkg::reg_addr_t zxuno_addr,
  input  logic                 regrd,
  input  logic                 regaddr_changed,
  output logic                 oe_coreid,
  output zxuno_pkg::byte_t     coreid_dout
);

  logic [zxuno_pkg::COREID_IDX_W-1:0] idx;
  logic                               regrd_q;
  logic                               sel;
  logic                               rd_done;
  logic [8*zxuno_pkg::COREID_LEN-1:0] str_window;

  assign sel = (zxuno_addr == zxuno_pkg::REG_COREID);

  // falling edge of the read strobe ends one access
  assign rd_done = regrd_q & ~regrd & sel;

  // ----------------------------------------------------------
  // string index
  // ----------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      idx     <= '0;
      regrd_q <= 1'b0;
    end else begin
      regrd_q <= regrd;
      // new address selects the string from the start
      if (regaddr_changed) begin
        idx <= '0;
      end else if (rd_done && idx != zxuno_pkg::COREID_LEN) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // current char shifted into the top byte
  // past the end the shift leaves zeros, so 00 is read
  assign str_window  = zxuno_pkg::COREID_STR << {idx, 3'b000};
  assign coreid_dout = str_window[8*zxuno_pkg::COREID_LEN-1 -: 8];

  assign oe_coreid = regrd & sel;

  // index rewind never collides with a string read
  assert property (@(posedge sysclk) disable iff (rst) regaddr_changed |-> !regrd)
    else $error("regaddr_changed during a data port read");

endmodule

/* hw/option_registers.sv */
`timescale 1ns/1ns

module option_registers (
  input  logic                    sysclk,
  input  logic                    rst,
  input  zxuno_pkg::reg_addr_t    zxuno_addr,
  input  logic                    regrd,
  input  logic                    regwr,
  input  zxuno_pkg::byte_t        d_in,
  output logic                    oe_options,
  output zxuno_pkg::byte_t        options_dout,
  output zxuno_pkg::byte_t        devoptions,
  output zxuno_pkg::raster_line_t raster_line,
  output logic                    rasterint_enable,
  output logic                    vretraceint_disable
);

  zxuno_pkg::byte_t scratch_q;
  zxuno_pkg::byte_t devoptions_q;
  zxuno_pkg::byte_t rasterline_q;
  // only three bits of raster control are implemented
  logic [2:0]       rasterctrl_q;

  logic sel_scratch;
  logic sel_devoptions;
  logic sel_rasterline;
  logic sel_rasterctrl;

  // ----------------------------------------------------------
  // register select
  // ----------------------------------------------------------
  assign sel_scratch    = (zxuno_addr == zxuno_pkg::REG_SCRATCH);
  assign sel_devoptions = (zxuno_addr == zxuno_pkg::REG_DEVOPTIONS);
  assign sel_rasterline = (zxuno_addr == zxuno_pkg::REG_RASTERLINE);
  assign sel_rasterctrl = (zxuno_addr == zxuno_pkg::REG_RASTERCTRL);

  // ----------------------------------------------------------
  // write side
  // ----------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      scratch_q    <= zxuno_pkg::SCRATCH_RST;
      devoptions_q <= zxuno_pkg::DEVOPTIONS_RST;
      rasterline_q <= zxuno_pkg::RASTERLINE_RST;
      rasterctrl_q <= zxuno_pkg::RASTERCTRL_RST[2:0];
    end else if (regwr) begin
      if (sel_scratch) begin
        scratch_q <= d_in;
      end
      if (sel_devoptions) begin
        devoptions_q <= d_in;
      end
      if (sel_rasterline) begin
        rasterline_q <= d_in;
      end
      // bits 7..3 dropped on write
      if (sel_rasterctrl) begin
        rasterctrl_q <= d_in[2:0];
      end
    end
  end

  // ----------------------------------------------------------
  // readback
  // ----------------------------------------------------------
  assign oe_options = regrd &
                      (sel_scratch | sel_devoptions | sel_rasterline | sel_rasterctrl);

  always_comb begin
    unique case (1'b1)
      sel_scratch:    options_dout = scratch_q;
      sel_devoptions: options_dout = devoptions_q;
      sel_rasterline: options_dout = rasterline_q;
      // unused control bits read as 0
      sel_rasterctrl: options_dout = {5'b00000, rasterctrl_q};
      default:        options_dout = '0;
    endcase
  end

  // control outputs
  // disable flags straight from device options
  assign devoptions = devoptions_q;
  // line bit 8 sits in control bit 0
  assign raster_line         = {rasterctrl_q[0], rasterline_q};
  assign rasterint_enable    = rasterctrl_q[1];
  assign vretraceint_disable = rasterctrl_q[2];

  // a readback never overlaps a write strobe
  assert property (@(posedge sysclk) disable iff (rst) !(regrd && regwr))
    else $error("regrd and regwr high in the same cycle");

endmodule

/* hw/cpu_read_mux.sv */
`timescale 1ns/1ns

module cpu_read_mux (
  input  logic             oe_addr,
  input  zxuno_pkg::byte_t addr_dout,
  input  logic             oe_coreid,
  input  zxuno_pkg::byte_t coreid_dout,
  input  logic             oe_options,
  input  zxuno_pkg::byte_t options_dout,
  output zxuno_pkg::byte_t d_out
);

  // ----------------------------------------------------------
  // priority read select
  // ----------------------------------------------------------

  // first oe wins
  // order is address latch, string, option registers
  always_comb begin
    if (oe_addr) begin
      d_out = addr_dout;
    end else if (oe_coreid) begin
      d_out = coreid_dout;
    end else if (oe_options) begin
      d_out = options_dout;
    end else begin
      // no device claims the cycle
      d_out = zxuno_pkg::FLOATING_BUS;
    end
  end

  // ----------------------------------------------------------
  // bus ownership
  // ----------------------------------------------------------

  // decoder and register devices never claim the same cycle,
  // priority order only matters if that breaks
  assert final ($onehot0({oe_addr, oe_coreid, oe_options}))
    else $error("more than one read source enabled");

endmodule

/* hw/zxuno_regbank.sv */
`timescale 1ns/1ns

module zxuno_regbank (
  input  logic                    sysclk,
  input  logic                    rst,
  input  zxuno_pkg::io_addr_t     a,
  input  zxuno_pkg::byte_t        d_in,
  input  logic                    iorq_n,
  input  logic                    rd_n,
  input  logic                    wr_n,
  output zxuno_pkg::byte_t        d_out,
  output zxuno_pkg::byte_t        devoptions,
  output zxuno_pkg::raster_line_t raster_line,
  output logic                    rasterint_enable,
  output logic                    vretraceint_disable
);

  // register access strobes
  zxuno_pkg::reg_addr_t zxuno_addr;
  logic                 regrd;
  logic                 regwr;
  logic                 regaddr_changed;

  // read sources toward the mux
  logic                 oe_addr;
  zxuno_pkg::byte_t     addr_dout;
  logic                 oe_coreid;
  zxuno_pkg::byte_t     coreid_dout;
  logic                 oe_options;
  zxuno_pkg::byte_t     options_dout;

  // ----------------------------------------------------------
  // input side
  // ----------------------------------------------------------
  zxuno_port_decoder u_port_decoder (
    .sysclk          (sysclk),
    .rst             (rst),
    .a               (a),
    .d_in            (d_in),
    .iorq_n          (iorq_n),
    .rd_n            (rd_n),
    .wr_n            (wr_n),
    .zxuno_addr      (zxuno_addr),
    .regrd           (regrd),
    .regwr           (regwr),
    .regaddr_changed (regaddr_changed),
    .oe_addr         (oe_addr),
    .addr_dout       (addr_dout)
  );

  // ----------------------------------------------------------
  // register devices
  // ----------------------------------------------------------
  coreid_string u_coreid_string (
    .sysclk          (sysclk),
    .rst             (rst),
    .zxuno_addr      (zxuno_addr),
    .regrd           (regrd),
    .regaddr_changed (regaddr_changed),
    .oe_coreid       (oe_coreid),
    .coreid_dout     (coreid_dout)
  );

  option_registers u_option_registers (
    .sysclk              (sysclk),
    .rst                 (rst),
    .zxuno_addr          (zxuno_addr),
    .regrd               (regrd),
    .regwr               (regwr),
    .d_in                (d_in),
    .oe_options          (oe_options),
    .options_dout        (options_dout),
    .devoptions          (devoptions),
    .raster_line         (raster_line),
    .rasterint_enable    (rasterint_enable),
    .vretraceint_disable (vretraceint_disable)
  );

  // output side, back to the cpu
  cpu_read_mux u_cpu_read_mux (
    .oe_addr      (oe_addr),
    .addr_dout    (addr_dout),
    .oe_coreid    (oe_coreid),
    .coreid_dout  (coreid_dout),
    .oe_options   (oe_options),
    .options_dout (options_dout),
    .d_out        (d_out)
  );

endmodule

/* test/tb_zxuno_model.svh */
`ifndef TB_ZXUNO_MODEL_SVH
`define TB_ZXUNO_MODEL_SVH

// ------------------------------------------------------------
// register image as the cpu should see it
// ------------------------------------------------------------
zxuno_pkg::reg_addr_t img_addr;
zxuno_pkg::byte_t     img_scratch;
zxuno_pkg::byte_t     img_devoptions;
zxuno_pkg::byte_t     img_rasterline;
// only bits 2..0 kept, upper bits always 0
zxuno_pkg::byte_t     img_rasterctrl;
int                   img_idx;

function automatic void model_reset();
  img_addr       = '0;
  img_scratch    = '0;
  img_devoptions = '0;
  img_rasterline = '0;
  img_rasterctrl = '0;
  img_idx        = 0;
endfunction

// character n of the id string, 00 past the end
function automatic zxuno_pkg::byte_t coreid_char(input int n);
  if (n >= zxuno_pkg::COREID_LEN)
    return 8'h00;
  // first character in the top byte of the literal
  return zxuno_pkg::COREID_STR[8*(zxuno_pkg::COREID_LEN-1-n) +: 8];
endfunction

// apply one bus write to the image
function automatic void model_write(input zxuno_pkg::io_addr_t port,
                                    input zxuno_pkg::byte_t data);
  if (port == zxuno_pkg::PORT_ADDR) begin
    img_addr = data;
    // any address write rewinds the string
    img_idx  = 0;
  end else if (port == zxuno_pkg::PORT_DATA) begin
    case (img_addr)
      zxuno_pkg::REG_SCRATCH:    img_scratch    = data;
      zxuno_pkg::REG_DEVOPTIONS: img_devoptions = data;
      zxuno_pkg::REG_RASTERLINE: img_rasterline = data;
      zxuno_pkg::REG_RASTERCTRL: img_rasterctrl = {5'b00000, data[2:0]};
      default: ;
    endcase
  end
endfunction

// expected byte of one bus read, string index moves on afterwards
function automatic zxuno_pkg::byte_t expected_read(input zxuno_pkg::io_addr_t port);
  zxuno_pkg::byte_t v;
  // floating bus unless a register answers
  v = 8'hFF;
  if (port == zxuno_pkg::PORT_ADDR) begin
    v = img_addr;
  end else if (port == zxuno_pkg::PORT_DATA) begin
    case (img_addr)
      zxuno_pkg::REG_COREID: begin
        v = coreid_char(img_idx);
        if (img_idx < zxuno_pkg::COREID_LEN)
          img_idx++;
      end
      zxuno_pkg::REG_SCRATCH:    v = img_scratch;
      zxuno_pkg::REG_DEVOPTIONS: v = img_devoptions;
      zxuno_pkg::REG_RASTERLINE: v = img_rasterline;
      zxuno_pkg::REG_RASTERCTRL: v = img_rasterctrl;
      default: ;
    endcase
  end
  return v;
endfunction

`endif

/* test/tb_zxuno_regbank.sv */
`timescale 1ns/1ns

module tb_zxuno_regbank;

  localparam int DRIVE_DLY = 5;
  // bus accesses per section: reset, scratch/devopt, raster, id, latch, other ports
  localparam int NUM_ACCESSES = 9 + 24 + 24 + 15 + 10 + 8;
  // three cycles per access, four times headroom
  localparam int CYCLE_LIMIT = 4 * NUM_ACCESSES * 3;

  logic                    sysclk;
  logic                    rst;
  zxuno_pkg::io_addr_t     a;
  zxuno_pkg::byte_t        d_in;
  logic                    iorq_n;
  logic                    rd_n;
  logic                    wr_n;
  zxuno_pkg::byte_t        d_out;
  zxuno_pkg::byte_t        devoptions;
  zxuno_pkg::raster_line_t raster_line;
  logic                    rasterint_enable;
  logic                    vretraceint_disable;

  integer           seed = 32'hf1a6;
  int               rd_errors = 0;
  int               ctl_errors = 0;
  int               cycles;
  logic             check_rd;
  logic             check_ctl;
  zxuno_pkg::byte_t exp_rd;

  zxuno_pkg::reg_addr_t opt_regs[4] = '{zxuno_pkg::REG_SCRATCH, zxuno_pkg::REG_DEVOPTIONS,
                                        zxuno_pkg::REG_RASTERLINE, zxuno_pkg::REG_RASTERCTRL};

  `include "tb_zxuno_model.svh"

  zxuno_regbank DUT (
    .sysclk              (sysclk),
    .rst                 (rst),
    .a                   (a),
    .d_in                (d_in),
    .iorq_n              (iorq_n),
    .rd_n                (rd_n),
    .wr_n                (wr_n),
    .d_out               (d_out),
    .devoptions          (devoptions),
    .raster_line         (raster_line),
    .rasterint_enable    (rasterint_enable),
    .vretraceint_disable (vretraceint_disable)
  );

  initial begin
    sysclk = 1'b0;
    forever #50 sysclk = ~sysclk;
  end

  // watchdog on total run length
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge sysclk);
      cycles++;
    end
    $display("run timed out after %0d cycles without finishing the tests", cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // compare, sampled mid cycle where d_out is settled
  // ------------------------------------------------------------
  always @(negedge sysclk) begin
    if (check_rd) begin
      assert (d_out === exp_rd) else begin
        rd_errors++;
        $display("FAIL d_out expected %h got %h (a=%h)", exp_rd, d_out, a);
      end
      check_rd = 1'b0;
    end
    if (check_ctl) begin
      assert (devoptions === img_devoptions) else begin
        ctl_errors++;
        $display("FAIL devoptions expected %h got %h", img_devoptions, devoptions);
      end
      // control bit 0 is line bit 8
      assert (raster_line === {img_rasterctrl[0], img_rasterline}) else begin
        ctl_errors++;
        $display("FAIL raster_line expected %h got %h",
                 {img_rasterctrl[0], img_rasterline}, raster_line);
      end
      assert (rasterint_enable === img_rasterctrl[1]) else begin
        ctl_errors++;
        $display("FAIL rasterint_enable expected %h got %h", img_rasterctrl[1],
                 rasterint_enable);
      end
      assert (vretraceint_disable === img_rasterctrl[2]) else begin
        ctl_errors++;
        $display("FAIL vretraceint_disable expected %h got %h", img_rasterctrl[2],
                 vretraceint_disable);
      end
      check_ctl = 1'b0;
    end
  end

  // ------------------------------------------------------------
  // z80 bus cycles, two active cycles then one idle
  // ------------------------------------------------------------
  task automatic io_write(input zxuno_pkg::io_addr_t port, input zxuno_pkg::byte_t data);
    @(posedge sysclk);
    #DRIVE_DLY;
    a      = port;
    d_in   = data;
    iorq_n = 1'b0;
    wr_n   = 1'b0;
    model_write(port, data);
    repeat (2) @(posedge sysclk);
    #DRIVE_DLY;
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    // write landed, outputs checked in the idle cycle
    check_ctl = 1'b1;
  endtask

  task automatic io_read(input zxuno_pkg::io_addr_t port);
    @(posedge sysclk);
    #DRIVE_DLY;
    exp_rd = expected_read(port);
    a      = port;
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    @(posedge sysclk);
    #DRIVE_DLY;
    check_rd = 1'b1;
    @(posedge sysclk);
    #DRIVE_DLY;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
  endtask

  task automatic select_reg(input zxuno_pkg::reg_addr_t num);
    io_write(zxuno_pkg::PORT_ADDR, num);
  endtask

  task automatic write_then_read(input zxuno_pkg::reg_addr_t num,
                                 input zxuno_pkg::byte_t data);
    select_reg(num);
    io_write(zxuno_pkg::PORT_DATA, data);
    io_read(zxuno_pkg::PORT_DATA);
  endtask

  function automatic zxuno_pkg::byte_t rand_byte();
    return zxuno_pkg::byte_t'($random(seed));
  endfunction

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    rst       = 1'b1;
    a         = '0;
    d_in      = '0;
    iorq_n    = 1'b1;
    rd_n      = 1'b1;
    wr_n      = 1'b1;
    check_rd  = 1'b0;
    check_ctl = 1'b0;
    model_reset();
    repeat (4) @(posedge sysclk);
    #DRIVE_DLY;
    rst = 1'b0;

    // reset state
    io_read(zxuno_pkg::PORT_ADDR);
    @(posedge sysclk);
    #DRIVE_DLY;
    check_ctl = 1'b1;
    foreach (opt_regs[i]) begin
      select_reg(opt_regs[i]);
      io_read(zxuno_pkg::PORT_DATA);
    end

    // scratch, device options, raster registers
    repeat (4) begin
      write_then_read(zxuno_pkg::REG_SCRATCH, rand_byte());
      write_then_read(zxuno_pkg::REG_DEVOPTIONS, rand_byte());
    end
    repeat (4) begin
      write_then_read(zxuno_pkg::REG_RASTERLINE, rand_byte());
      write_then_read(zxuno_pkg::REG_RASTERCTRL, rand_byte());
    end

    // id string runs out into 00, then restarts
    select_reg(zxuno_pkg::REG_COREID);
    repeat (zxuno_pkg::COREID_LEN + 2) io_read(zxuno_pkg::PORT_DATA);
    select_reg(zxuno_pkg::REG_COREID);
    repeat (3) io_read(zxuno_pkg::PORT_DATA);

    // latch readback, unknown number floats
    repeat (4) begin
      select_reg(rand_byte());
      io_read(zxuno_pkg::PORT_ADDR);
    end
    select_reg(8'h42);
    io_read(zxuno_pkg::PORT_DATA);

    // foreign ports leave everything alone
    select_reg(zxuno_pkg::REG_DEVOPTIONS);
    io_write(16'h7FFD, rand_byte());
    io_write(16'hFC3A, rand_byte());
    io_write(16'hFD3C, rand_byte());
    io_read(zxuno_pkg::PORT_DATA);
    io_read(zxuno_pkg::PORT_ADDR);
    io_read(16'h7FFD);
    io_read(16'hFC3A);

    repeat (2) @(posedge sysclk);
    $display("errors: read %0d, control %0d", rd_errors, ctl_errors);
    if (rd_errors == 0 && ctl_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* zxuno_regbank.f */
+incdir+test
hw/zxuno_pkg.sv
hw/zxuno_port_decoder.sv
hw/coreid_string.sv
hw/option_registers.sv
hw/cpu_read_mux.sv
hw/zxuno_regbank.sv
test/tb_zxuno_regbank.sv

/* Bender.yml */
package:
  name: zxuno_regbank

sources:
  - hw/zxuno_pkg.sv
  - hw/zxuno_port_decoder.sv
  - hw/coreid_string.sv
  - hw/option_registers.sv
  - hw/cpu_read_mux.sv
  - hw/zxuno_regbank.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_zxuno_regbank.sv
